//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // memory operation from execute.
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lbu  = 4'd2,
        op_lh   = 4'd3,
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // request from execute with wdata as the unaligned store value.
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic [31:0] pass_data;
    } lsu_req_t;

    // result to writeback.
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        fault;
    } lsu_resp_t;

    // one request in flight at a time.
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_addr = 2'd1,
        st_resp = 2'd2,
        st_done = 2'd3
    } lsu_state_e;

endpackage

`default_nettype wire

//--- source/axi_pkg.sv
`default_nettype none

package axi_pkg;

    typedef enum logic [2:0] {
        size_byte = 3'd0,
        size_half = 3'd1,
        size_word = 3'd2
    } axi_size_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // shared by aw and ar.
    typedef struct packed {
        logic [31:0] addr;
        axi_size_e   size;
    } axi_ax_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    // sram window.
    localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
    localparam int          MEM_WORDS = 256;
    localparam int          MEM_IDX_W = $clog2(MEM_WORDS);

endpackage

`default_nettype wire

//--- source/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  wire lsu_pkg::mem_op_e op,
    input  wire [1:0]             offset,
    input  wire [31:0]            rdata,
    output logic [31:0]           data
);
    import lsu_pkg::*;

    logic [31:0] shifted;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // bring the addressed lane down to bit 0.
    assign shifted  = rdata >> {offset, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (op)
            op_lb: begin
                data = {{24{byte_val[7]}}, byte_val};
            end
            op_lbu: begin
                data = {24'h0, byte_val};
            end
            op_lh: begin
                data = {{16{half_val[15]}}, half_val};
            end
            op_lhu: begin
                data = {16'h0, half_val};
            end
            op_lw: begin
                data = rdata;
            end
            default: begin
                data = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/lsu_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_access_ctrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  req_valid,
    output logic                 req_ready,
    input  wire lsu_pkg::lsu_req_t req,
    output logic                 resp_valid,
    input  wire                  resp_ready,
    output lsu_pkg::lsu_resp_t   resp,
    output logic                 awvalid,
    input  wire                  awready,
    output axi_pkg::axi_ax_t     aw,
    output logic                 wvalid,
    input  wire                  wready,
    output axi_pkg::axi_w_t      w,
    input  wire                  bvalid,
    output logic                 bready,
    input  wire axi_pkg::axi_b_t b,
    output logic                 arvalid,
    input  wire                  arready,
    output axi_pkg::axi_ax_t     ar,
    input  wire                  rvalid,
    output logic                 rready,
    input  wire axi_pkg::axi_r_t r
);
    import lsu_pkg::*;
    import axi_pkg::*;

    lsu_state_e  st;
    mem_op_e     op_q;
    logic [4:0]  rd_q;
    logic [1:0]  offset_q;
    logic [1:0]  req_off;
    axi_size_e   req_size;
    logic [3:0]  base_strb;
    logic        req_misaligned;
    logic        aw_left;
    logic        w_left;
    logic        ar_left;
    logic        bus_fault;
    logic [31:0] load_data;

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    assign req_ready = (st == st_idle);
    assign req_off   = req.addr[1:0];

    // access width and alignment rule per op.
    always_comb begin
        case (req.op)
            op_lb, op_lbu, op_sb: begin
                req_size       = size_byte;
                base_strb      = 4'b0001;
                req_misaligned = 1'b0;
            end
            op_lh, op_lhu, op_sh: begin
                req_size       = size_half;
                base_strb      = 4'b0011;
                req_misaligned = req.addr[0];
            end
            default: begin
                req_size       = size_word;
                base_strb      = 4'b1111;
                req_misaligned = (req_off != 2'b00);
            end
        endcase
    end

    // a channel is still open if valid is up and this cycle brings no ready.
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;
    assign ar_left = arvalid && !arready;

    assign bus_fault = bready ? (b.resp != resp_okay) : (r.resp != resp_okay);

    load_extract i_load_extract (
        .op     (op_q),
        .offset (offset_q),
        .rdata  (r.data),
        .data   (load_data)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= st_idle;
            op_q       <= op_none;
            rd_q       <= 5'd0;
            offset_q   <= 2'd0;
            resp_valid <= 1'b0;
            resp       <= '0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            arvalid    <= 1'b0;
            bready     <= 1'b0;
            rready     <= 1'b0;
            aw         <= '0;
            w          <= '0;
            ar         <= '0;
        end else begin
            case (st)
                st_idle: begin
                    if (req_valid) begin
                        op_q     <= req.op;
                        rd_q     <= req.rd;
                        offset_q <= req_off;
                        if (req.op == op_none) begin
                            resp_valid <= 1'b1;
                            resp       <= '{rd: req.rd, data: req.pass_data, fault: 1'b0};
                            st         <= st_done;
                        end else if (req_misaligned) begin
                            // faulted here without any bus traffic.
                            resp_valid <= 1'b1;
                            resp       <= '{rd: req.rd, data: 32'h0, fault: 1'b1};
                            st         <= st_done;
                        end else if (is_store(req.op)) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            aw      <= '{addr: req.addr, size: req_size};
                            w       <= '{data: req.wdata << {req_off, 3'b000},
                                         strb: base_strb << req_off};
                            st      <= st_addr;
                        end else begin
                            arvalid <= 1'b1;
                            ar      <= '{addr: req.addr, size: req_size};
                            st      <= st_addr;
                        end
                    end
                end
                st_addr: begin
                    if (awvalid && awready) awvalid <= 1'b0;
                    if (wvalid && wready) wvalid <= 1'b0;
                    if (arvalid && arready) arvalid <= 1'b0;
                    if (!aw_left && !w_left && !ar_left) begin
                        bready <= is_store(op_q);
                        rready <= !is_store(op_q);
                        st     <= st_resp;
                    end
                end
                st_resp: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bready     <= 1'b0;
                        rready     <= 1'b0;
                        resp_valid <= 1'b1;
                        resp       <= '{rd: rd_q,
                                        data: (bready || bus_fault) ? 32'h0 : load_data,
                                        fault: bus_fault};
                        st         <= st_done;
                    end
                end
                st_done: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        st         <= st_idle;
                    end
                end
                default: begin
                    st <= st_idle;
                end
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw));
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w));
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar));
    // one access at a time, so reads and writes never overlap.
    a_aw_ar_excl: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && arvalid));
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

//--- source/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire axi_pkg::axi_ax_t aw,
    input  wire                   wvalid,
    output logic                  wready,
    input  wire axi_pkg::axi_w_t  w,
    output logic                  bvalid,
    input  wire                   bready,
    output axi_pkg::axi_b_t       b,
    input  wire                   arvalid,
    output logic                  arready,
    input  wire axi_pkg::axi_ax_t ar,
    output logic                  rvalid,
    input  wire                   rready,
    output axi_pkg::axi_r_t       r
);
    import axi_pkg::*;

    logic [31:0]          mem [MEM_WORDS];
    logic                 wr_ready_q;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 aw_hit;
    logic                 ar_hit;
    logic [MEM_IDX_W-1:0] aw_idx;
    logic [MEM_IDX_W-1:0] ar_idx;

    function automatic logic in_window(logic [31:0] addr);
        logic [31:0] rel;
        rel = addr - MEM_BASE;
        return rel < 32'(MEM_WORDS * 4);
    endfunction

    // aw and w are taken together, so one flop drives both readies.
    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    assign aw_hit = in_window(aw.addr);
    assign ar_hit = in_window(ar.addr);
    assign aw_idx = aw.addr[MEM_IDX_W+1:2];
    assign ar_idx = ar.addr[MEM_IDX_W+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ready_q <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            // single-cycle ready pulse once both write channels are up.
            wr_ready_q <= awvalid && wvalid && !wr_ready_q && !bvalid;
            arready    <= arvalid && !arready && !rvalid;

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b.resp <= aw_hit ? resp_okay : resp_slverr;
            if (aw_hit) begin
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i]) begin
                        mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
            end
        end
        if (rd_fire) begin
            r.resp <= ar_hit ? resp_okay : resp_slverr;
            r.data <= ar_hit ? mem[ar_idx] : 32'h0;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(b));
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

`default_nettype wire

//--- source/lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req_valid,
    output logic                   req_ready,
    input  wire lsu_pkg::lsu_req_t req,
    output logic                   resp_valid,
    input  wire                    resp_ready,
    output lsu_pkg::lsu_resp_t     resp
);
    import axi_pkg::*;

    logic    awvalid;
    logic    awready;
    axi_ax_t aw;
    logic    wvalid;
    logic    wready;
    axi_w_t  w;
    logic    bvalid;
    logic    bready;
    axi_b_t  b;
    logic    arvalid;
    logic    arready;
    axi_ax_t ar;
    logic    rvalid;
    logic    rready;
    axi_r_t  r;

    lsu_access_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .b          (b),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r)
    );

    axi_sram_slave i_sram (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

endmodule

`default_nettype wire

//--- dv/lsu_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_tb;
    import lsu_pkg::*;
    import axi_pkg::*;

    localparam int CLK_NS  = 4;
    localparam int N_WORDS = 16;
    localparam int N_RAND  = 40;
    // pass-through, fill, random stores and loads, window, misaligned, stalled mix.
    localparam int N_REQ   = 2 + N_WORDS + 2 * N_RAND + 6 + 7 + N_RAND;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    lsu_req_t    req;
    logic        resp_valid;
    logic        resp_ready;
    lsu_resp_t   resp;
    logic [31:0] model [MEM_WORDS];
    logic [31:0] rng_state;
    logic [4:0]  next_rd;

    lsu_mem_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    always #(CLK_NS / 2) clk = ~clk;

    initial begin
        #((N_REQ * 40 + 20) * CLK_NS);
        $display("timeout: the requests did not all complete in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // expected load result built byte by byte from the model.
    function automatic logic [31:0] expect_load(mem_op_e op, logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  lo;
        logic [15:0] half;
        word = model[(addr - MEM_BASE) >> 2];
        lo   = word[8 * addr[1:0] +: 8];
        half = addr[1] ? word[31:16] : word[15:0];
        case (op)
            op_lb:   return {{24{lo[7]}}, lo};
            op_lbu:  return {24'h0, lo};
            op_lh:   return {{16{half[15]}}, half};
            op_lhu:  return {16'h0, half};
            default: return word;
        endcase
    endfunction

    task automatic model_store(mem_op_e op, logic [31:0] addr, logic [31:0] data);
        int idx;
        int off;
        int n;
        idx = (addr - MEM_BASE) >> 2;
        off = addr[1:0];
        n   = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model[idx][8 * (off + i) +: 8] = data[8 * i +: 8];
        end
    endtask

    function automatic logic [31:0] rand_addr(mem_op_e op);
        logic [31:0] a;
        a = MEM_BASE + 4 * (next_rand() % N_WORDS);
        if (op inside {op_lb, op_lbu, op_sb}) begin
            a = a + next_rand() % 4;
        end else if (op inside {op_lh, op_lhu, op_sh}) begin
            a = a + 2 * (next_rand() % 2);
        end
        return a;
    endfunction

    // one request with resp_ready held high or stalled for a few cycles.
    task automatic issue(input lsu_req_t rq, input logic stall, output lsu_resp_t rs,
                         output int lat);
        int hold;
        @(posedge clk);
        req_valid  <= 1'b1;
        req        <= rq;
        resp_ready <= !stall;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        rs = resp;
        if (stall) begin
            hold = next_rand() % 4;
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                check_eq("resp_valid during stall", resp_valid, 1'b1);
                check_eq("resp during stall", resp, rs);
            end
            @(posedge clk);
            resp_ready <= 1'b1;
        end
        @(posedge clk);
        resp_ready <= !stall;
        @(negedge clk);
        check_eq("resp_valid after handshake", resp_valid, 1'b0);
        check_eq("req_ready after handshake", req_ready, 1'b1);
    endtask

    task automatic access(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic stall);
        lsu_req_t    rq;
        lsu_resp_t   rs;
        int          lat;
        logic        store;
        logic        misaligned;
        logic        mapped;
        store      = op inside {op_sb, op_sh, op_sw};
        misaligned = (op inside {op_lh, op_lhu, op_sh} && addr[0]) ||
                     (op inside {op_lw, op_sw} && addr[1:0] != 2'b00);
        mapped     = addr >= MEM_BASE && addr < MEM_BASE + 32'(4 * MEM_WORDS);
        rq = '{op: op, addr: addr, wdata: wdata, rd: next_rd, pass_data: 32'h0};
        issue(rq, stall, rs, lat);
        check_eq("resp.rd", rs.rd, rq.rd);
        check_eq("resp.fault", rs.fault, misaligned || !mapped);
        if (misaligned || !mapped) begin
            check_eq("resp.data", rs.data, 32'h0);
        end else if (!store) begin
            check_eq("resp.data", rs.data, expect_load(op, addr));
        end
        if (misaligned) begin
            check_eq("misaligned latency", lat, 1);
        end else begin
            check_eq("memory latency at least 4", lat >= 4, 1'b1);
            if (store && mapped) begin
                model_store(op, addr, wdata);
            end
        end
        next_rd++;
    endtask

    task automatic after_reset();
        @(negedge clk);
        check_eq("req_ready after reset", req_ready, 1'b1);
        check_eq("resp_valid after reset", resp_valid, 1'b0);
    endtask

    task automatic pass_through();
        lsu_req_t  rq;
        lsu_resp_t rs;
        int        lat;
        for (int i = 0; i < 2; i++) begin
            rq = '{op: op_none, addr: next_rand(), wdata: next_rand(), rd: next_rd,
                   pass_data: next_rand()};
            issue(rq, 1'b0, rs, lat);
            check_eq("pass resp.rd", rs.rd, rq.rd);
            check_eq("pass resp.data", rs.data, rq.pass_data);
            check_eq("pass resp.fault", rs.fault, 1'b0);
            check_eq("pass latency", lat, 1);
            next_rd++;
        end
    endtask

    task automatic store_load();
        mem_op_e op;
        for (int i = 0; i < N_WORDS; i++) begin
            access(op_sw, MEM_BASE + 4 * i, next_rand(), 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            op = mem_op_e'(4'(6 + next_rand() % 3));
            access(op, rand_addr(op), next_rand(), 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            op = mem_op_e'(4'(1 + next_rand() % 5));
            access(op, rand_addr(op), 32'h0, 1'b0);
        end
    endtask

    task automatic out_of_window();
        // these two would alias onto words 2 and 1 if the window were not checked.
        access(op_sw, MEM_BASE + 4 * MEM_WORDS + 8, 32'hdead_beef, 1'b0);
        access(op_sb, 32'h0000_0004, 32'h0000_005a, 1'b0);
        access(op_lw, MEM_BASE + 4 * MEM_WORDS, 32'h0, 1'b0);
        access(op_lbu, 32'h0000_0010, 32'h0, 1'b0);
        access(op_lw, MEM_BASE + 8, 32'h0, 1'b0);
        access(op_lw, MEM_BASE + 4, 32'h0, 1'b0);
    endtask

    task automatic misaligned_access();
        access(op_lh, MEM_BASE + 12 + 1, 32'h0, 1'b0);
        access(op_lhu, MEM_BASE + 12 + 3, 32'h0, 1'b0);
        access(op_sh, MEM_BASE + 20 + 1, 32'h1234_5678, 1'b0);
        access(op_lw, MEM_BASE + 12 + 2, 32'h0, 1'b0);
        access(op_sw, MEM_BASE + 24 + 3, 32'h8765_4321, 1'b0);
        access(op_lw, MEM_BASE + 20, 32'h0, 1'b0);
        access(op_lw, MEM_BASE + 24, 32'h0, 1'b0);
    endtask

    task automatic stall_order();
        mem_op_e op;
        for (int i = 0; i < N_RAND; i++) begin
            if (next_rand() % 8 < 5) begin
                op = mem_op_e'(4'(1 + next_rand() % 5));
            end else begin
                op = mem_op_e'(4'(6 + next_rand() % 3));
            end
            access(op, rand_addr(op), next_rand(), 1'b1);
        end
    endtask

    initial begin
        rng_state  = 32'd29283;
        next_rd    = 5'd1;
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        pass_through();
        store_load();
        out_of_window();
        misaligned_access();
        stall_order();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/lsu_pkg.sv
source/axi_pkg.sv
source/load_extract.sv
source/lsu_access_ctrl.sv
source/axi_sram_slave.sv
source/lsu_mem_top.sv
dv/lsu_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module lsu_mem_tb -o lsu_mem_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/lsu_mem_sim > sim.log 2>&1
cat sim.log

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
